// File: logic/cmd_link_pkg.sv
package cmd_link_pkg;

    localparam int FRAME_LEN  = 18;        // Bytes per command frame
    localparam int RD_LATENCY = 2;         // Frame RAM read latency
    localparam logic [15:0] STD_HEAD = 16'h55AA;
    localparam int TRIG_CH    = 2;         // Delays carried in one frame

    typedef enum logic [15:0] {
        FC_CONF = 16'h001E,
        FC_READ = 16'h004C,
        FC_STOP = 16'h0097,
        FC_RXD0 = 16'h002D,
        FC_RXD1 = 16'h00D2
    } func_code_t;

    typedef enum logic [3:0] {
        KIND_NONE = 4'h0,
        KIND_CONF = 4'h1,
        KIND_READ = 4'h2,
        KIND_STOP = 4'h3,
        KIND_RXD0 = 4'h4,
        KIND_RXD1 = 4'h5
    } cmd_kind_t;

    // One-hot parser states
    typedef enum logic [5:0] {
        PS_IDLE = 6'h01,
        PS_WAIT = 6'h02,
        PS_WORK = 6'h04,
        PS_TAKE = 6'h08,
        PS_REST = 6'h10,
        PS_DONE = 6'h20
    } parse_state_t;

    typedef enum logic {
        CS_IDLE  = 1'b0,
        CS_COUNT = 1'b1
    } chan_state_t;

    typedef struct packed {
        logic [3:0] rate;
        logic [3:0] lfilt;
        logic [3:0] hfilt;
    } acq_cfg_t;

    typedef struct packed {
        logic [3:0] ch_en;                      // Bit i enables channel i
        logic [3:0] mode;
        logic [0:TRIG_CH-1][15:0] dly;          // dly[0] sits in the upper half
    } trig_cfg_t;

    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        logic [7:0] data;
    } ram_wr_t;

endpackage

// File: logic/rx_frame_ram.sv
`timescale 1ns/1ps

module rx_frame_ram #(
    parameter int ADDR_W = 8
) (
    input  logic                 clk,
    input  cmd_link_pkg::ram_wr_t wr,
    input  logic [ADDR_W-1:0]    rd_addr,
    output logic [7:0]           rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [0:DEPTH-1];
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr_q;

    assign wr_addr = wr.addr[ADDR_W-1:0];

    // Ethernet side writes
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // Address stage then data stage
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
    end

endmodule

// File: logic/cmd_frame_parser.sv
`timescale 1ns/1ps

module cmd_frame_parser #(
    parameter logic [7:0] RAM_BASE = 8'h0A
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_rdy,
    input  logic                    cmd_ack,
    input  logic [15:0]             password,
    input  logic [7:0]              rd_data,
    output logic [7:0]              rd_addr,
    output logic                    frame_done,
    output logic                    cmd_rdy,
    output logic                    run_start,
    output logic                    run_stop,
    output cmd_link_pkg::cmd_kind_t kind,
    output cmd_link_pkg::acq_cfg_t  acq,
    output cmd_link_pkg::trig_cfg_t trig
);

    localparam int WORDS    = cmd_link_pkg::FRAME_LEN / 2;
    localparam int LOAD_OFS = cmd_link_pkg::RD_LATENCY + 1;   // Address to capture

    cmd_link_pkg::parse_state_t state, next_state;
    cmd_link_pkg::func_code_t   func;
    cmd_link_pkg::cmd_kind_t    code_kind;
    cmd_link_pkg::acq_cfg_t     conf_acq;
    cmd_link_pkg::trig_cfg_t    conf_trig;

    logic [7:0]  num;
    logic [7:0]  load_idx;
    logic        load_hit;
    logic [15:0] words [0:WORDS-1];
    logic [15:0] sum;
    logic        frame_ok;
    logic        pass_ok;
    logic        code_known;
    logic        accept;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cmd_link_pkg::PS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cmd_link_pkg::PS_IDLE: next_state = cmd_link_pkg::PS_WAIT;
            cmd_link_pkg::PS_WAIT: begin
                if (frame_rdy) next_state = cmd_link_pkg::PS_WORK;
            end
            cmd_link_pkg::PS_WORK: begin
                if (num >= 8'(cmd_link_pkg::FRAME_LEN + cmd_link_pkg::RD_LATENCY)) begin
                    next_state = cmd_link_pkg::PS_TAKE;
                end
            end
            cmd_link_pkg::PS_TAKE: next_state = cmd_link_pkg::PS_REST;
            cmd_link_pkg::PS_REST: begin
                if (!frame_rdy) next_state = cmd_link_pkg::PS_DONE;
            end
            cmd_link_pkg::PS_DONE: begin
                if (cmd_ack) next_state = cmd_link_pkg::PS_IDLE;
            end
            default: next_state = cmd_link_pkg::PS_IDLE;
        endcase
    end

    assign frame_done = (state == cmd_link_pkg::PS_REST);
    assign cmd_rdy    = (state == cmd_link_pkg::PS_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= 8'h00;
        end else if (state == cmd_link_pkg::PS_WORK) begin
            num <= num + 8'h01;
        end else begin
            num <= 8'h00;
        end
    end

    // Byte address runs ahead of the capture by LOAD_OFS counts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_addr <= RAM_BASE;
        end else if (state == cmd_link_pkg::PS_WORK && num < 8'(cmd_link_pkg::FRAME_LEN)) begin
            rd_addr <= RAM_BASE + num;
        end else begin
            rd_addr <= RAM_BASE;
        end
    end

    assign load_idx = num - 8'(LOAD_OFS);
    assign load_hit = (num >= 8'(LOAD_OFS)) &&
                      (num < 8'(LOAD_OFS + cmd_link_pkg::FRAME_LEN));

    always_ff @(posedge clk) begin
        if (state == cmd_link_pkg::PS_WORK && load_hit) begin
            if (load_idx[0]) begin
                words[load_idx[4:1]][7:0] <= rd_data;     // Odd byte is low half
            end else begin
                words[load_idx[4:1]][15:8] <= rd_data;
            end
        end
    end

    // Checksum over words 1 to 7
    always_comb begin
        sum = 16'h0000;
        for (int w = 1; w < WORDS - 1; w++) begin
            sum = sum + words[w];
        end
    end

    assign func     = cmd_link_pkg::func_code_t'(words[2]);
    assign frame_ok = (words[0] == cmd_link_pkg::STD_HEAD) && (sum == words[WORDS-1]);
    assign pass_ok  = (words[1] == password);

    always_comb begin
        code_known = 1'b1;
        case (func)
            cmd_link_pkg::FC_CONF: code_kind = cmd_link_pkg::KIND_CONF;
            cmd_link_pkg::FC_READ: code_kind = cmd_link_pkg::KIND_READ;
            cmd_link_pkg::FC_STOP: code_kind = cmd_link_pkg::KIND_STOP;
            cmd_link_pkg::FC_RXD0: code_kind = cmd_link_pkg::KIND_RXD0;
            cmd_link_pkg::FC_RXD1: code_kind = cmd_link_pkg::KIND_RXD1;
            default: begin
                code_kind  = cmd_link_pkg::KIND_NONE;
                code_known = 1'b0;
            end
        endcase
    end

    assign accept = (state == cmd_link_pkg::PS_TAKE) && frame_ok && pass_ok && code_known;

    assign run_start = accept && (func == cmd_link_pkg::FC_READ);
    assign run_stop  = accept && (func == cmd_link_pkg::FC_STOP);

    // Unpack CONF fields
    always_comb begin
        conf_acq.rate   = words[3][3:0];
        conf_acq.lfilt  = words[4][11:8];
        conf_acq.hfilt  = words[4][3:0];
        conf_trig.ch_en = words[5][11:8];
        conf_trig.mode  = words[5][3:0];
        for (int c = 0; c < cmd_link_pkg::TRIG_CH; c++) begin
            conf_trig.dly[c] = words[6+c];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kind <= cmd_link_pkg::KIND_NONE;
            acq  <= '0;
            trig <= '0;
        end else if (state == cmd_link_pkg::PS_TAKE) begin
            if (!frame_ok) begin
                acq  <= '0;                             // Damaged frame
                trig <= '0;
            end else if (accept) begin
                kind <= code_kind;
                if (func == cmd_link_pkg::FC_CONF) begin
                    acq  <= conf_acq;
                    trig <= conf_trig;
                end
            end
        end
    end

endmodule

// File: logic/trig_delay_chan.sv
`timescale 1ns/1ps

module trig_delay_chan (
    input  logic        clk,
    input  logic        rst,
    input  logic        run_start,
    input  logic        run_stop,
    input  logic        en,
    input  logic [15:0] dly,
    output logic        fire,
    output logic        busy
);

    cmd_link_pkg::chan_state_t state;

    logic [15:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cmd_link_pkg::CS_IDLE;
            cnt   <= 16'h0000;
        end else if (run_stop) begin
            state <= cmd_link_pkg::CS_IDLE;           // Abort without a fire
        end else if (run_start && en) begin
            state <= cmd_link_pkg::CS_COUNT;
            cnt   <= dly;
        end else if (state == cmd_link_pkg::CS_COUNT) begin
            if (cnt == 16'h0000) begin
                state <= cmd_link_pkg::CS_IDLE;
            end else begin
                cnt <= cnt - 16'h0001;
            end
        end
    end

    // Zero count in COUNT is cycle dly + 1 after the start pulse
    assign fire = (state == cmd_link_pkg::CS_COUNT) && (cnt == 16'h0000) && !run_stop;
    assign busy = (state == cmd_link_pkg::CS_COUNT);

endmodule

// File: logic/trig_merge.sv
`timescale 1ns/1ps

module trig_merge (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [cmd_link_pkg::TRIG_CH-1:0] fire,
    input  logic [cmd_link_pkg::TRIG_CH-1:0] busy,
    output logic                            trig_out,
    output logic [7:0]                      fire_count,
    output logic                            run_busy
);

    logic [7:0] fire_num;

    // Channels firing this cycle
    always_comb begin
        fire_num = 8'h00;
        for (int c = 0; c < cmd_link_pkg::TRIG_CH; c++) begin
            fire_num = fire_num + 8'(fire[c]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_out   <= 1'b0;
            fire_count <= 8'h00;
            run_busy   <= 1'b0;
        end else begin
            trig_out   <= |fire;
            fire_count <= fire_count + fire_num;    // Wraps at 256
            run_busy   <= |busy;
        end
    end

endmodule

// File: logic/cmd_link_top.sv
`timescale 1ns/1ps

module cmd_link_top #(
    parameter int         ADDR_W   = 8,
    parameter logic [7:0] RAM_BASE = 8'h0A
) (
    input  logic                    clk,
    input  logic                    rst,
    input  cmd_link_pkg::ram_wr_t   wr,
    input  logic                    frame_rdy,
    input  logic                    cmd_ack,
    input  logic [15:0]             password,
    output logic                    frame_done,
    output logic                    cmd_rdy,
    output cmd_link_pkg::cmd_kind_t kind,
    output cmd_link_pkg::acq_cfg_t  acq,
    output cmd_link_pkg::trig_cfg_t trig,
    output logic                    trig_out,
    output logic                    run_busy,
    output logic [7:0]              fire_count
);

    logic [7:0] rd_addr;
    logic [7:0] rd_data;
    logic       run_start;
    logic       run_stop;
    logic [cmd_link_pkg::TRIG_CH-1:0] fire;
    logic [cmd_link_pkg::TRIG_CH-1:0] busy;

    rx_frame_ram #(
        .ADDR_W (ADDR_W)
    ) u_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr[ADDR_W-1:0]),
        .rd_data (rd_data)
    );

    cmd_frame_parser #(
        .RAM_BASE (RAM_BASE)
    ) u_parser (
        .clk        (clk),
        .rst        (rst),
        .frame_rdy  (frame_rdy),
        .cmd_ack    (cmd_ack),
        .password   (password),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .frame_done (frame_done),
        .cmd_rdy    (cmd_rdy),
        .run_start  (run_start),
        .run_stop   (run_stop),
        .kind       (kind),
        .acq        (acq),
        .trig       (trig)
    );

    // One delay channel per frame delay word
    for (genvar i = 0; i < cmd_link_pkg::TRIG_CH; i++) begin : g_chan
        trig_delay_chan u_chan (
            .clk       (clk),
            .rst       (rst),
            .run_start (run_start),
            .run_stop  (run_stop),
            .en        (trig.ch_en[i]),
            .dly       (trig.dly[i]),
            .fire      (fire[i]),
            .busy      (busy[i])
        );
    end

    trig_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .fire       (fire),
        .busy       (busy),
        .trig_out   (trig_out),
        .fire_count (fire_count),
        .run_busy   (run_busy)
    );

endmodule

// File: verif/cmd_link_tb.sv
`timescale 1ns/1ps

module cmd_link_tb;

    localparam int         NUM_TESTS = 12;
    localparam int         REC_W     = 228;
    localparam int         ADDR_W    = 8;
    localparam logic [7:0] RAM_BASE  = 8'h0A;
    localparam real        CLK_PER   = 40.0;
    localparam int         RST_CYC   = 10;
    localparam longint     WD_CYCLES = longint'(NUM_TESTS) *
                                       (cmd_link_pkg::FRAME_LEN + 40 + 2 * 65536) + RST_CYC;

    logic                    clk;
    logic                    rst;
    cmd_link_pkg::ram_wr_t   wr;
    logic                    frame_rdy;
    logic                    cmd_ack;
    logic [15:0]             password;
    logic                    frame_done;
    logic                    cmd_rdy;
    cmd_link_pkg::cmd_kind_t kind;
    cmd_link_pkg::acq_cfg_t  acq;
    cmd_link_pkg::trig_cfg_t trig;
    logic                    trig_out;
    logic                    run_busy;
    logic [7:0]              fire_count;

    logic [REC_W-1:0] tdata [0:NUM_TESTS-1];
    integer           seed = 32'h4144;
    int               test_errs;
    int               passed;
    int               failed;
    int               trig_pulses;
    logic [7:0]       prev_count;

    cmd_link_top #(
        .ADDR_W   (ADDR_W),
        .RAM_BASE (RAM_BASE)
    ) uut (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .frame_rdy  (frame_rdy),
        .cmd_ack    (cmd_ack),
        .password   (password),
        .frame_done (frame_done),
        .cmd_rdy    (cmd_rdy),
        .kind       (kind),
        .acq        (acq),
        .trig       (trig),
        .trig_out   (trig_out),
        .run_busy   (run_busy),
        .fire_count (fire_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PER / 2) clk = ~clk;
    end

    // Cycles with trig_out high
    always @(negedge clk) begin
        if (trig_out === 1'b1) trig_pulses <= trig_pulses + 1;
    end

    initial begin
        #(WD_CYCLES * CLK_PER);
        $display("Watchdog expired before the test sequence finished");
        $display("tests failed");
        $finish;
    end

    task automatic check_kind(input string sig, input cmd_link_pkg::cmd_kind_t got,
                              input cmd_link_pkg::cmd_kind_t exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %0h expected %0h", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_acq(input string sig, input cmd_link_pkg::acq_cfg_t got,
                             input cmd_link_pkg::acq_cfg_t exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %03h expected %03h", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_trig(input string sig, input cmd_link_pkg::trig_cfg_t got,
                              input cmd_link_pkg::trig_cfg_t exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %010h expected %010h", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_count(input string sig, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %02h expected %02h", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %b expected %b", $time, sig, got, exp);
            test_errs++;
        end
    endtask

    // Frame bytes sit MSB first in the record
    task automatic write_frame(input logic [REC_W-1:0] rec);
        for (int b = 0; b < cmd_link_pkg::FRAME_LEN; b++) begin
            @(posedge clk);
            wr.en   <= 1'b1;
            wr.addr <= RAM_BASE + 8'(b);
            wr.data <= rec[REC_W-1-8*b -: 8];
        end
        @(posedge clk);
        wr <= '0;
    endtask

    task automatic run_test(input int t);
        logic [REC_W-1:0]        rec;
        cmd_link_pkg::cmd_kind_t exp_kind;
        cmd_link_pkg::acq_cfg_t  exp_acq;
        cmd_link_pkg::trig_cfg_t exp_trig;
        logic [7:0]              exp_count;
        logic                    exp_busy;
        int                      gap;
        int                      pulses_before;
        rec           = tdata[t];
        exp_kind      = cmd_link_pkg::cmd_kind_t'(rec[67:64]);
        exp_acq       = cmd_link_pkg::acq_cfg_t'(rec[63:52]);
        exp_trig      = cmd_link_pkg::trig_cfg_t'(rec[51:12]);
        exp_count     = rec[11:4];
        exp_busy      = rec[0];
        test_errs     = 0;
        pulses_before = trig_pulses;

        write_frame(rec);
        password  <= rec[83:68];
        frame_rdy <= 1'b1;
        do @(negedge clk); while (frame_done !== 1'b1);
        @(posedge clk);
        frame_rdy <= 1'b0;
        do @(negedge clk); while (cmd_rdy !== 1'b1);

        check_kind("kind", kind, exp_kind);
        check_acq("acq", acq, exp_acq);
        check_trig("trig", trig, exp_trig);
        @(posedge clk);
        cmd_ack <= 1'b1;
        @(posedge clk);
        cmd_ack <= 1'b0;

        // Idle gap long enough for short delays to fire
        gap = 4 + ($unsigned($random(seed)) % 8);
        repeat (gap) @(posedge clk);
        @(negedge clk);
        check_count("fire_count", fire_count, exp_count);
        check_flag("run_busy", run_busy, exp_busy);
        if ((trig_pulses != pulses_before) != (exp_count != prev_count)) begin
            $display("trig_out pulses at %0t do not agree with the fire count change", $time);
            test_errs++;
        end
        prev_count = exp_count;

        if (test_errs == 0) begin
            passed++;
            $display("Test %0d: PASS", t);
        end else begin
            failed++;
            $display("Test %0d: FAIL with %0d errors", t, test_errs);
        end
    endtask

    initial begin
        rst         = 1'b1;
        wr          = '0;
        frame_rdy   = 1'b0;
        cmd_ack     = 1'b0;
        password    = 16'h0000;
        passed      = 0;
        failed      = 0;
        trig_pulses = 0;
        prev_count  = 8'h00;
        $readmemh("verif/cmd_link_testdata.txt", tdata);

        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);

        if ($isunknown(tdata[NUM_TESTS-1])) begin
            $display("Test data file is missing or shorter than %0d records", NUM_TESTS);
            failed = NUM_TESTS;
        end else begin
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_test(t);
            end
        end

        $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, passed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: cmd_link_top.f
logic/cmd_link_pkg.sv
logic/rx_frame_ram.sv
logic/cmd_frame_parser.sv
logic/trig_delay_chan.sv
logic/trig_merge.sv
logic/cmd_link_top.sv
verif/cmd_link_tb.sv

// File: verif/cmd_link_testdata.txt
// Frame words 0..8 (head didx func rate filt trgg dly0 dly1 part) _ password _ kind
// _ acq (rate lfilt hfilt) _ trig (ch_en mode dly0 dly1) _ fire_count _ run_busy after the gap
// Valid CONF, both channels, short delays
55AA_A51C_001E_0007_0309_0302_0003_0005_AB54_A51C_1_739_3200030005_00_0
// READ fires both channels
55AA_A51C_004C_0000_0000_0000_0000_0000_A568_A51C_2_739_3200030005_02_0
// Bad checksum clears acq and trig
55AA_A51C_001E_0008_0808_0303_0001_0001_0000_A51C_2_000_0000000000_02_0
// Valid CONF, channel 0 only
55AA_A51C_001E_0005_0A04_0101_0010_0020_B074_A51C_1_5A4_1100100020_02_0
// Wrong password changes nothing
55AA_1234_001E_000F_0F0F_0F0F_1111_2222_63B2_A51C_1_5A4_1100100020_02_0
// Bad header with a good checksum
55AB_A51C_001E_0001_0101_0301_0002_0002_A941_A51C_1_000_0000000000_02_0
// Valid CONF, both channels, long delays
55AA_A51C_001E_0002_0601_0303_4000_5000_3E40_A51C_1_261_3340005000_02_0
// READ then STOP before any fire
55AA_A51C_004C_0000_0000_0000_0000_0000_A568_A51C_2_261_3340005000_02_1
55AA_A51C_0097_0000_0000_0000_0000_0000_A5B3_A51C_3_261_3340005000_02_0
// RXD0, RXD1, then an unknown code
55AA_A51C_002D_0000_0000_0000_0000_0000_A549_A51C_4_261_3340005000_02_0
55AA_A51C_00D2_0000_0000_0000_0000_0000_A5EE_A51C_5_261_3340005000_02_0
55AA_A51C_0055_0000_0000_0000_0000_0000_A571_A51C_5_261_3340005000_02_0
